// ==== logic/mmc_pkg.sv ====
package mmc_pkg;

  // ********************************************************************
  // Local bus data and register map
  // ********************************************************************

  typedef logic [7:0] lb_data_t;

  typedef enum logic [2:0] {
    REG_DAT_O    = 3'd0,
    REG_DAT_I    = 3'd1,
    REG_CMD_O    = 3'd2,
    REG_CMD_I    = 3'd3,
    REG_OENS     = 3'd4,
    REG_STATUS   = 3'd5,
    REG_ADV_TYPE = 3'd6,
    REG_ADV_MAN  = 3'd7
  } reg_addr_e;

  // Codes 5 to 7 act as manual
  typedef enum logic [2:0] {
    ADV_MANUAL = 3'd0,
    ADV_CMD_RD = 3'd1,
    ADV_CMD_WR = 3'd2,
    ADV_DAT_RD = 3'd3,
    ADV_DAT_WR = 3'd4
  } adv_type_e;

  // ********************************************************************
  // Reset levels and status layout
  // ********************************************************************

  localparam logic CMD_IDLE          = 1'b1;  // Card command line idles high
  localparam int   STATUS_DONE_BIT   = 4;
  localparam int   STATUS_DETECT_BIT = 0;

endpackage

// ==== logic/mmc_lb_regs.sv ====
module mmc_lb_regs (
  input  logic                lb_clk,
  input  logic                lb_rst,

  // Local bus
  input  logic                lb_stb_i,
  input  logic                lb_we_i,
  input  mmc_pkg::reg_addr_e  lb_adr_i,
  input  mmc_pkg::lb_data_t   lb_dat_i,
  output mmc_pkg::lb_data_t   lb_dat_o,

  // Status sources
  input  logic                trans_done_i,
  input  logic                mmc_detect_i,

  // Line io state for read-back
  input  mmc_pkg::lb_data_t   dat_cap_i,
  input  logic                cmd_cap_i,
  input  mmc_pkg::lb_data_t   dat_out_i,
  input  logic                cmd_out_i,
  input  logic                cmd_oen_i,
  input  logic                dat_oen_i,

  // Strobes
  output logic                adv_req_o,
  output logic                dat_wr_o,
  output logic                cmd_wr_o,
  output logic                oens_wr_o
);

  mmc_pkg::adv_type_e adv_type;

  logic wr_acc;
  logic rd_acc;
  logic adv_man;
  logic adv_dat;
  logic adv_cmd;

  assign wr_acc = lb_stb_i & lb_we_i;
  assign rd_acc = lb_stb_i & ~lb_we_i;

  // ********************************************************************
  // Write decode
  // ********************************************************************

  assign dat_wr_o  = wr_acc && (lb_adr_i == mmc_pkg::REG_DAT_O);
  assign cmd_wr_o  = wr_acc && (lb_adr_i == mmc_pkg::REG_CMD_O);
  assign oens_wr_o = wr_acc && (lb_adr_i == mmc_pkg::REG_OENS);

  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      adv_type <= mmc_pkg::ADV_MANUAL;
    end else if (wr_acc && (lb_adr_i == mmc_pkg::REG_ADV_TYPE)) begin
      adv_type <= mmc_pkg::adv_type_e'(lb_dat_i[2:0]);  // Unlisted codes kept as written
    end
  end

  // ********************************************************************
  // Advance request
  // ********************************************************************

  assign adv_man = wr_acc && (lb_adr_i == mmc_pkg::REG_ADV_MAN);

  assign adv_dat = (wr_acc && (lb_adr_i == mmc_pkg::REG_DAT_O) &&
                    (adv_type == mmc_pkg::ADV_DAT_WR)) ||
                   (rd_acc && (lb_adr_i == mmc_pkg::REG_DAT_I) &&
                    (adv_type == mmc_pkg::ADV_DAT_RD));

  assign adv_cmd = (wr_acc && (lb_adr_i == mmc_pkg::REG_CMD_O) &&
                    (adv_type == mmc_pkg::ADV_CMD_WR)) ||
                   (rd_acc && (lb_adr_i == mmc_pkg::REG_CMD_I) &&
                    (adv_type == mmc_pkg::ADV_CMD_RD));

  assign adv_req_o = adv_man | adv_dat | adv_cmd;

  // Read mux with same-cycle data
  always_comb begin
    lb_dat_o = '0;
    case (lb_adr_i)
      mmc_pkg::REG_DAT_O:    lb_dat_o = dat_out_i;
      mmc_pkg::REG_DAT_I:    lb_dat_o = dat_cap_i;  // Previous pulse's capture
      mmc_pkg::REG_CMD_O:    lb_dat_o[0] = cmd_out_i;
      mmc_pkg::REG_CMD_I:    lb_dat_o[0] = cmd_cap_i;
      mmc_pkg::REG_OENS:     lb_dat_o = {6'b0, dat_oen_i, cmd_oen_i};
      mmc_pkg::REG_STATUS: begin
        lb_dat_o[mmc_pkg::STATUS_DONE_BIT]   = trans_done_i;
        lb_dat_o[mmc_pkg::STATUS_DETECT_BIT] = mmc_detect_i;
      end
      mmc_pkg::REG_ADV_TYPE: lb_dat_o = {5'b0, adv_type};
      default:               lb_dat_o = '0;  // ADV_MAN is write only
    endcase
  end

endmodule

// ==== logic/mmc_clk_gen.sv ====
module mmc_clk_gen (
  input  logic lb_clk,
  input  logic lb_rst,

  input  logic adv_req_i,

  output logic mmc_clk_o,
  output logic sample_o,
  output logic trans_done_o
);

  logic [1:0] pulse_cnt;

  // ********************************************************************
  // Pulse counter
  // ********************************************************************

  // Requests while busy are dropped
  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      pulse_cnt <= 2'd0;
    end else if (pulse_cnt != 2'd0) begin
      pulse_cnt <= pulse_cnt - 2'd1;
    end else if (adv_req_i) begin
      pulse_cnt <= 2'd3;
    end
  end

  assign mmc_clk_o    = ~pulse_cnt[1];         // Low while count is 3 or 2
  assign trans_done_o = (pulse_cnt == 2'd0);
  assign sample_o     = (pulse_cnt == 2'd2);   // Capture edge is the card clock rise

  // Card clock low for two cycles, sample on the second
  a_sample_after_fall: assert property (
    @(posedge lb_clk) disable iff (lb_rst)
    $fell(mmc_clk_o) |=> sample_o
  ) else $error("sample_o missing one cycle after the card clock fall");

  a_rise_after_sample: assert property (
    @(posedge lb_clk) disable iff (lb_rst)
    sample_o |=> $rose(mmc_clk_o) && !trans_done_o
  ) else $error("Card clock did not rise after sample_o");

endmodule

// ==== logic/mmc_line_io.sv ====
module mmc_line_io #(
  parameter int SYNC_STAGES = 2
) (
  input  logic              lb_clk,
  input  logic              lb_rst,

  // Bus byte and write strobes
  input  mmc_pkg::lb_data_t lb_dat_i,
  input  logic              dat_wr_i,
  input  logic              cmd_wr_i,
  input  logic              oens_wr_i,
  input  logic              sample_i,

  // Card pins
  input  logic              mmc_cmd_i,
  input  mmc_pkg::lb_data_t mmc_data_i,
  output logic              mmc_cmd_o,
  output logic              mmc_cmd_oen_o,
  output mmc_pkg::lb_data_t mmc_data_o,
  output logic              mmc_data_oen_o,

  // Captured inputs
  output logic              cmd_cap_o,
  output mmc_pkg::lb_data_t dat_cap_o
);

  logic [SYNC_STAGES-1:0] cmd_sync;
  mmc_pkg::lb_data_t      dat_sync [SYNC_STAGES];

  // ********************************************************************
  // Output lines and enables
  // ********************************************************************

  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      mmc_cmd_o      <= mmc_pkg::CMD_IDLE;
      mmc_data_o     <= '0;
      mmc_cmd_oen_o  <= 1'b0;
      mmc_data_oen_o <= 1'b0;
    end else begin
      if (dat_wr_i) begin
        mmc_data_o <= lb_dat_i;
      end
      if (cmd_wr_i) begin
        mmc_cmd_o <= lb_dat_i[0];
      end
      if (oens_wr_i) begin
        mmc_cmd_oen_o  <= lb_dat_i[0];
        mmc_data_oen_o <= lb_dat_i[1];
      end
    end
  end

  // ********************************************************************
  // Input synchronizers and capture
  // ********************************************************************

  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      cmd_sync <= '0;
      for (int i = 0; i < SYNC_STAGES; i++) begin
        dat_sync[i] <= '0;
      end
    end else begin
      cmd_sync    <= {cmd_sync[SYNC_STAGES-2:0], mmc_cmd_i};
      dat_sync[0] <= mmc_data_i;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        dat_sync[i] <= dat_sync[i-1];
      end
    end
  end

  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      cmd_cap_o <= 1'b0;
      dat_cap_o <= '0;
    end else if (sample_i) begin  // Rising edge of the card clock
      cmd_cap_o <= cmd_sync[SYNC_STAGES-1];
      dat_cap_o <= dat_sync[SYNC_STAGES-1];
    end
  end

  // Register decode gives one strobe per access
  a_wr_onehot: assert property (
    @(posedge lb_clk) disable iff (lb_rst)
    $onehot0({dat_wr_i, cmd_wr_i, oens_wr_i})
  ) else $error("Overlapping line write strobes");

endmodule

// ==== logic/mmc_host.sv ====
module mmc_host #(
  parameter int SYNC_STAGES = 2
) (
  input  logic               lb_clk,
  input  logic               lb_rst,

  // Local bus
  input  logic               lb_stb_i,
  input  logic               lb_we_i,
  input  mmc_pkg::reg_addr_e lb_adr_i,
  input  mmc_pkg::lb_data_t  lb_dat_i,
  output mmc_pkg::lb_data_t  lb_dat_o,

  // Card pins
  output logic               mmc_clk_o,
  input  logic               mmc_cmd_i,
  output logic               mmc_cmd_o,
  output logic               mmc_cmd_oen_o,
  input  mmc_pkg::lb_data_t  mmc_data_i,
  output mmc_pkg::lb_data_t  mmc_data_o,
  output logic               mmc_data_oen_o,
  input  logic               mmc_detect_i
);

  logic              adv_req;
  logic              sample;
  logic              trans_done;
  logic              dat_wr;
  logic              cmd_wr;
  logic              oens_wr;
  logic              cmd_cap;
  mmc_pkg::lb_data_t dat_cap;

  mmc_lb_regs u_regs (
    .lb_clk       (lb_clk),
    .lb_rst       (lb_rst),
    .lb_stb_i     (lb_stb_i),
    .lb_we_i      (lb_we_i),
    .lb_adr_i     (lb_adr_i),
    .lb_dat_i     (lb_dat_i),
    .lb_dat_o     (lb_dat_o),
    .trans_done_i (trans_done),
    .mmc_detect_i (mmc_detect_i),
    .dat_cap_i    (dat_cap),
    .cmd_cap_i    (cmd_cap),
    .dat_out_i    (mmc_data_o),
    .cmd_out_i    (mmc_cmd_o),
    .cmd_oen_i    (mmc_cmd_oen_o),
    .dat_oen_i    (mmc_data_oen_o),
    .adv_req_o    (adv_req),
    .dat_wr_o     (dat_wr),
    .cmd_wr_o     (cmd_wr),
    .oens_wr_o    (oens_wr)
  );

  mmc_clk_gen u_clk_gen (
    .lb_clk       (lb_clk),
    .lb_rst       (lb_rst),
    .adv_req_i    (adv_req),
    .mmc_clk_o    (mmc_clk_o),
    .sample_o     (sample),
    .trans_done_o (trans_done)
  );

  mmc_line_io #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_line_io (
    .lb_clk         (lb_clk),
    .lb_rst         (lb_rst),
    .lb_dat_i       (lb_dat_i),
    .dat_wr_i       (dat_wr),
    .cmd_wr_i       (cmd_wr),
    .oens_wr_i      (oens_wr),
    .sample_i       (sample),
    .mmc_cmd_i      (mmc_cmd_i),
    .mmc_data_i     (mmc_data_i),
    .mmc_cmd_o      (mmc_cmd_o),
    .mmc_cmd_oen_o  (mmc_cmd_oen_o),
    .mmc_data_o     (mmc_data_o),
    .mmc_data_oen_o (mmc_data_oen_o),
    .cmd_cap_o      (cmd_cap),
    .dat_cap_o      (dat_cap)
  );

endmodule

// ==== tests/mmc_host_tb.sv ====
module mmc_host_tb;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_WAIT} op_e;

  typedef struct packed {
    op_e                op;
    mmc_pkg::reg_addr_e adr;
    mmc_pkg::lb_data_t  wdat;
    mmc_pkg::lb_data_t  card_dat;
    logic               card_cmd;
    logic               card_det;
    mmc_pkg::lb_data_t  exp;
    logic [3:0]         n_pulse;   // Card clock rises since previous entry
  } entry_t;

  localparam int CLK_PERIOD = 4;

  logic               lb_clk = 1'b0;
  logic               lb_rst;
  logic               lb_stb_i;
  logic               lb_we_i;
  mmc_pkg::reg_addr_e lb_adr_i;
  mmc_pkg::lb_data_t  lb_dat_i;
  mmc_pkg::lb_data_t  lb_dat_o;
  logic               mmc_clk_o;
  logic               mmc_cmd_i;
  logic               mmc_cmd_o;
  logic               mmc_cmd_oen_o;
  mmc_pkg::lb_data_t  mmc_data_i;
  mmc_pkg::lb_data_t  mmc_data_o;
  logic               mmc_data_oen_o;
  logic               mmc_detect_i;

  entry_t            tbl[$];
  mmc_pkg::lb_data_t cur_dat;
  logic              cur_cmd;
  logic              cur_det;
  logic              tbl_ready = 1'b0;
  int                edge_cnt = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;

  mmc_host #(.SYNC_STAGES(2)) dut0 (.*);

  always #(CLK_PERIOD / 2) lb_clk = ~lb_clk;

  always @(posedge mmc_clk_o) begin
    if (!lb_rst) begin
      edge_cnt++;
    end
  end

  // ********************************************************************
  // Compare tasks
  // ********************************************************************

  task automatic check_byte(input string name, input mmc_pkg::lb_data_t got,
                            input mmc_pkg::lb_data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_cnt++;
    end else begin
      $display("ok %s = 0x%h", name, got);
      pass_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_cnt++;
    end else begin
      $display("ok %s = 0x%h", name, got);
      pass_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      fail_cnt++;
    end else begin
      $display("ok %s = 0x%0h", name, got);
      pass_cnt++;
    end
  endtask

  function automatic mmc_pkg::lb_data_t status_byte(input logic done, input logic det);
    mmc_pkg::lb_data_t b;
    b = '0;
    b[mmc_pkg::STATUS_DONE_BIT]   = done;
    b[mmc_pkg::STATUS_DETECT_BIT] = det;
    return b;
  endfunction

  // ********************************************************************
  // Table building and replay
  // ********************************************************************

  task automatic set_card(input mmc_pkg::lb_data_t dat, input logic cmd, input logic det);
    cur_dat = dat;
    cur_cmd = cmd;
    cur_det = det;
  endtask

  task automatic add_entry(input op_e op, input mmc_pkg::reg_addr_e adr,
                           input mmc_pkg::lb_data_t wdat, input mmc_pkg::lb_data_t exp,
                           input int npulse);
    entry_t e;
    e.op       = op;
    e.adr      = adr;
    e.wdat     = wdat;
    e.card_dat = cur_dat;
    e.card_cmd = cur_cmd;
    e.card_det = cur_det;
    e.exp      = exp;
    e.n_pulse  = 4'(npulse);
    tbl.push_back(e);
  endtask

  task automatic apply_entry(input entry_t e, input int idx);
    string tag;
    int    last_cnt;
    tag      = $sformatf("entry %0d", idx);
    last_cnt = edge_cnt;
    @(negedge lb_clk);
    mmc_data_i   = e.card_dat;
    mmc_cmd_i    = e.card_cmd;
    mmc_detect_i = e.card_det;
    lb_stb_i     = 1'b1;
    lb_we_i      = (e.op == OP_WR);
    lb_adr_i     = (e.op == OP_WAIT) ? mmc_pkg::REG_STATUS : e.adr;
    lb_dat_i     = e.wdat;
    #1;  // Read data settles by mid low phase
    if (e.op == OP_WAIT) begin
      while (!lb_dat_o[mmc_pkg::STATUS_DONE_BIT]) begin
        @(negedge lb_clk);
        #1;
      end
      check_bit({tag, " mmc_clk_o"}, mmc_clk_o, 1'b1);
    end else if (e.op == OP_RD) begin
      check_byte({tag, " lb_dat_o"}, lb_dat_o, e.exp);
      case (e.adr)
        mmc_pkg::REG_DAT_O: check_byte({tag, " mmc_data_o"}, mmc_data_o, e.exp);
        mmc_pkg::REG_CMD_O: check_bit({tag, " mmc_cmd_o"}, mmc_cmd_o, e.exp[0]);
        mmc_pkg::REG_OENS: begin
          check_bit({tag, " mmc_cmd_oen_o"}, mmc_cmd_oen_o, e.exp[0]);
          check_bit({tag, " mmc_data_oen_o"}, mmc_data_oen_o, e.exp[1]);
        end
        default: ;
      endcase
    end
    check_count({tag, " mmc_clk rises"}, edge_cnt - last_cnt, int'(e.n_pulse));
  endtask

  initial begin
    logic [31:0]       rnd;
    mmc_pkg::lb_data_t r0;
    mmc_pkg::lb_data_t r1;
    mmc_pkg::lb_data_t r2;
    logic              c0;
    logic              c1;
    logic              c2;
    void'($urandom(32'hace5_c8ec));
    lb_rst       = 1'b1;
    lb_stb_i     = 1'b0;
    lb_we_i      = 1'b0;
    lb_adr_i     = mmc_pkg::REG_DAT_O;
    lb_dat_i     = '0;
    mmc_cmd_i    = 1'b0;
    mmc_data_i   = '0;
    mmc_detect_i = 1'b1;
    rnd = $urandom;
    r0  = rnd[7:0];
    c0  = rnd[8];
    rnd = $urandom;
    r1  = rnd[7:0];
    c1  = rnd[8];
    rnd = $urandom;
    r2  = rnd[7:0];
    c2  = ~c1;  // Forces a visible change on the cmd capture

    // Reset state
    set_card(8'h00, 1'b0, 1'b1);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b1, 1'b1), 0);
    set_card(8'h00, 1'b0, 1'b0);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b1, 1'b0), 0);
    set_card(8'h00, 1'b0, 1'b1);
    add_entry(OP_RD, mmc_pkg::REG_OENS, 8'h00, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_ADV_TYPE, 8'h00, {5'b0, mmc_pkg::ADV_MANUAL}, 0);
    add_entry(OP_RD, mmc_pkg::REG_CMD_O, 8'h00, {7'b0, mmc_pkg::CMD_IDLE}, 0);
    // Write and read back
    add_entry(OP_WR, mmc_pkg::REG_DAT_O, 8'ha5, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_DAT_O, 8'h00, 8'ha5, 0);
    add_entry(OP_WR, mmc_pkg::REG_CMD_O, 8'hfe, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_CMD_O, 8'h00, 8'h00, 0);
    add_entry(OP_WR, mmc_pkg::REG_OENS, 8'h03, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_OENS, 8'h00, 8'h03, 0);
    add_entry(OP_WR, mmc_pkg::REG_OENS, 8'h02, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_OENS, 8'h00, 8'h02, 0);
    add_entry(OP_WR, mmc_pkg::REG_ADV_TYPE, {5'b0, mmc_pkg::ADV_DAT_RD}, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_ADV_TYPE, 8'h00, {5'b0, mmc_pkg::ADV_DAT_RD}, 0);
    add_entry(OP_WR, mmc_pkg::REG_ADV_TYPE, {5'b0, mmc_pkg::ADV_MANUAL}, 8'h00, 0);
    // Manual advance and capture, then a dropped back-to-back request
    set_card(r0, c0, 1'b1);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b1, 1'b1), 0);
    add_entry(OP_WR, mmc_pkg::REG_ADV_MAN, 8'h00, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b0, 1'b1), 0);
    add_entry(OP_WAIT, mmc_pkg::REG_STATUS, 8'h00, 8'h00, 1);
    add_entry(OP_RD, mmc_pkg::REG_DAT_I, 8'h00, r0, 0);
    add_entry(OP_RD, mmc_pkg::REG_CMD_I, 8'h00, {7'b0, c0}, 0);
    add_entry(OP_WR, mmc_pkg::REG_ADV_MAN, 8'h00, 8'h00, 0);
    add_entry(OP_WR, mmc_pkg::REG_ADV_MAN, 8'h00, 8'h00, 0);
    // Pulse keeps the timing of the first write
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b0, 1'b1), 0);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b0, 1'b1), 1);
    add_entry(OP_WAIT, mmc_pkg::REG_STATUS, 8'h00, 8'h00, 0);
    // Automatic modes
    add_entry(OP_WR, mmc_pkg::REG_ADV_TYPE, {5'b0, mmc_pkg::ADV_DAT_WR}, 8'h00, 0);
    add_entry(OP_WR, mmc_pkg::REG_DAT_O, 8'h3c, 8'h00, 0);
    add_entry(OP_WAIT, mmc_pkg::REG_STATUS, 8'h00, 8'h00, 1);
    add_entry(OP_RD, mmc_pkg::REG_DAT_O, 8'h00, 8'h3c, 0);
    add_entry(OP_WR, mmc_pkg::REG_ADV_TYPE, {5'b0, mmc_pkg::ADV_CMD_WR}, 8'h00, 0);
    add_entry(OP_WR, mmc_pkg::REG_CMD_O, 8'h00, 8'h00, 0);
    add_entry(OP_WAIT, mmc_pkg::REG_STATUS, 8'h00, 8'h00, 1);
    set_card(r1, c1, 1'b1);
    add_entry(OP_WR, mmc_pkg::REG_ADV_TYPE, {5'b0, mmc_pkg::ADV_DAT_RD}, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_DAT_I, 8'h00, r0, 0);
    add_entry(OP_WAIT, mmc_pkg::REG_STATUS, 8'h00, 8'h00, 1);
    set_card(r2, c2, 1'b1);
    add_entry(OP_WR, mmc_pkg::REG_ADV_TYPE, {5'b0, mmc_pkg::ADV_CMD_RD}, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_CMD_I, 8'h00, {7'b0, c1}, 0);
    add_entry(OP_WAIT, mmc_pkg::REG_STATUS, 8'h00, 8'h00, 1);
    // Same accesses in manual mode give no pulse
    add_entry(OP_WR, mmc_pkg::REG_ADV_TYPE, {5'b0, mmc_pkg::ADV_MANUAL}, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_DAT_I, 8'h00, r2, 0);
    add_entry(OP_RD, mmc_pkg::REG_CMD_I, 8'h00, {7'b0, c2}, 0);
    add_entry(OP_WR, mmc_pkg::REG_DAT_O, 8'h5a, 8'h00, 0);
    add_entry(OP_WR, mmc_pkg::REG_CMD_O, 8'h01, 8'h00, 0);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b1, 1'b1), 0);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b1, 1'b1), 0);
    add_entry(OP_RD, mmc_pkg::REG_STATUS, 8'h00, status_byte(1'b1, 1'b1), 0);
    tbl_ready = 1'b1;

    repeat (5) @(posedge lb_clk);
    @(negedge lb_clk);
    lb_rst = 1'b0;
    #1;
    check_bit("reset mmc_clk_o", mmc_clk_o, 1'b1);
    check_bit("reset mmc_cmd_o", mmc_cmd_o, mmc_pkg::CMD_IDLE);
    foreach (tbl[i]) begin
      apply_entry(tbl[i], i);
    end
    @(negedge lb_clk);
    lb_stb_i = 1'b0;
    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog scaled to the table length
  initial begin
    wait (tbl_ready);
    #(tbl.size() * 20 * CLK_PERIOD);
    $display("Run timed out before all %0d table entries were applied", tbl.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== mmc_host.f ====
logic/mmc_pkg.sv
logic/mmc_lb_regs.sv
logic/mmc_clk_gen.sv
logic/mmc_line_io.sv
logic/mmc_host.sv
tests/mmc_host_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mmc_host_tb
FILELIST  ?= mmc_host.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
